/* hdl/RiscvIsaPkg.sv */
// ================================================
// RISC-V ISA definitions for the decode front end
// Major opcodes, B/J instruction views and
// displacement extraction
// ================================================
package RiscvIsaPkg;

    localparam int InsnBytes = 4;  // PC step per instruction

    // Major opcodes that matter for branch classification
    typedef enum logic [6:0] {
        OpOther   = 7'b0000000,
        OpMiscMem = 7'b0001111,  // FENCE
        OpBranch  = 7'b1100011,
        OpJalr    = 7'b1100111,
        OpJal     = 7'b1101111,
        OpSystem  = 7'b1110011
    } OpcodeT;

    // Conditional branch layout
    typedef struct packed {
        logic       immHi12;
        logic [5:0] immHi10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo4to1;
        logic       immLo11;
        logic [6:0] opcode;
    } BTypeT;

    // JAL layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } JTypeT;

    // One fetched word, seen either way
    typedef union packed {
        logic [31:0] raw;
        BTypeT       b;
        JTypeT       j;
    } InsnWord;

    // Sign-extended byte offset of a conditional branch
    function automatic logic [31:0] BranchDisplacement(InsnWord w);
        return {{19{w.b.immHi12}}, w.b.immHi12, w.b.immLo11,
                w.b.immHi10to5, w.b.immLo4to1, 1'b0};
    endfunction

    // Sign-extended byte offset of a JAL
    function automatic logic [31:0] JumpDisplacement(InsnWord w);
        return {{11{w.j.imm20}}, w.j.imm20, w.j.imm19to12,
                w.j.imm11, w.j.imm10to1, 1'b0};
    endfunction

endpackage

/* hdl/FrontEndPkg.sv */
// ================================================
// Front end pipeline definitions
// Widths, lane count and branch target classes
// ================================================
package FrontEndPkg;

    localparam int PcWidth            = 32;
    localparam int DefaultDecodeWidth = 4;  // Lanes per group

    // How the next address of a lane is known
    typedef enum logic [1:0] {
        ClsNext       = 2'd0,  // Falls through to pc+4
        ClsPcRelative = 2'd1,  // BRANCH, JAL
        ClsIndirect   = 2'd2,  // JALR, target unknown here
        ClsSerialized = 2'd3   // FENCE, SYSTEM
    } BranchClassT;

    // Width of an index that selects one of the lanes
    function automatic int LaneIdxWidth(int lanes);
        if (lanes > 1) begin
            return $clog2(lanes);
        end
        return 1;
    endfunction

endpackage

/* hdl/BranchPredecoder.sv */
// ================================================
// Branch predecoder, decode stage one
// Registers a fetch group, classifies each lane
// and computes its decoded next address
// ================================================
`timescale 1ns/1ps

module BranchPredecoder #(
    parameter int DecodeWidth = FrontEndPkg::DefaultDecodeWidth
) (
    input  logic                                                clk,
    input  logic                                                arstN,
    input  logic                                                inValid,
    output logic                                                inReady,
    input  logic [DecodeWidth-1:0]                              laneValidIn,
    input  logic [DecodeWidth-1:0][31:0]                        insn,
    input  logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    pc,
    input  logic [DecodeWidth-1:0]                              predTakenIn,
    input  logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    predAddrIn,
    output logic                                                downValid,
    input  logic                                                downReady,
    output logic [DecodeWidth-1:0]                              laneValid,
    output logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    pcOut,
    output logic [DecodeWidth-1:0]                              predTaken,
    output logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    predAddr,
    output FrontEndPkg::BranchClassT [DecodeWidth-1:0]          brClass,
    output logic [DecodeWidth-1:0]                              isJal,
    output logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    decodedPc
);

    localparam int PcW = FrontEndPkg::PcWidth;

    logic                                   fullQ;
    logic [DecodeWidth-1:0]                 laneValidQ;
    RiscvIsaPkg::InsnWord [DecodeWidth-1:0] insnQ;
    logic [DecodeWidth-1:0][PcW-1:0]        pcQ;
    logic [DecodeWidth-1:0]                 predTakenQ;
    logic [DecodeWidth-1:0][PcW-1:0]        predAddrQ;
    logic [DecodeWidth-1:0]                 laneValidInc;

    // Slot frees up when it is empty or its group leaves this cycle
    assign inReady = !fullQ || downReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fullQ <= 1'b0;
        end else if (inReady) begin
            fullQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            laneValidQ <= laneValidIn;
            pcQ        <= pc;
            predTakenQ <= predTakenIn;
            predAddrQ  <= predAddrIn;
            for (int i = 0; i < DecodeWidth; i++) begin
                insnQ[i].raw <= insn[i];
            end
        end
    end

    assign downValid = fullQ;
    assign laneValid = laneValidQ;
    assign pcOut     = pcQ;
    assign predTaken = predTakenQ;
    assign predAddr  = predAddrQ;

    always_comb begin
        for (int i = 0; i < DecodeWidth; i++) begin
            case (insnQ[i].b.opcode)
                RiscvIsaPkg::OpBranch,
                RiscvIsaPkg::OpJal:     brClass[i] = FrontEndPkg::ClsPcRelative;
                RiscvIsaPkg::OpJalr:    brClass[i] = FrontEndPkg::ClsIndirect;
                RiscvIsaPkg::OpMiscMem,
                RiscvIsaPkg::OpSystem:  brClass[i] = FrontEndPkg::ClsSerialized;
                default:                brClass[i] = FrontEndPkg::ClsNext;
            endcase
            isJal[i] = (insnQ[i].j.opcode == RiscvIsaPkg::OpJal);

            // Target from the displacement, otherwise the sequential address
            if (brClass[i] == FrontEndPkg::ClsPcRelative) begin
                if (isJal[i]) begin
                    decodedPc[i] = pcQ[i] + RiscvIsaPkg::JumpDisplacement(insnQ[i]);
                end else begin
                    decodedPc[i] = pcQ[i] + RiscvIsaPkg::BranchDisplacement(insnQ[i]);
                end
            end else begin
                decodedPc[i] = pcQ[i] + PcW'(RiscvIsaPkg::InsnBytes);
            end
        end
    end

    // Valid lanes form a run starting at lane 0
    assign laneValidInc = laneValidQ + 1'b1;

    assert property (@(posedge clk) disable iff (!arstN)
        downValid |-> (laneValidQ & laneValidInc) == '0);

endmodule

/* hdl/DecodedBranchResolver.sv */
// ================================================
// Decoded branch resolver, decode stage two
// Settles fetch predictions against the decoded
// targets, squashes younger lanes and redirects
// ================================================
`timescale 1ns/1ps

module DecodedBranchResolver #(
    parameter int DecodeWidth = FrontEndPkg::DefaultDecodeWidth
) (
    input  logic                                                clk,
    input  logic                                                arstN,
    input  logic                                                upValid,
    output logic                                                upReady,
    input  logic [DecodeWidth-1:0]                              laneValid,
    input  logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    pc,
    input  logic [DecodeWidth-1:0]                              predTaken,
    input  logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    predAddr,
    input  FrontEndPkg::BranchClassT [DecodeWidth-1:0]          brClass,
    input  logic [DecodeWidth-1:0]                              isJal,
    input  logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    decodedPc,
    output logic                                                outValid,
    input  logic                                                outReady,
    output logic [DecodeWidth-1:0]                              laneValidOut,
    output logic [DecodeWidth-1:0]                              laneFlushed,
    output logic [DecodeWidth-1:0]                              flushTriggering,
    output logic [DecodeWidth-1:0]                              predTakenOut,
    output logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    predAddrOut,
    output logic                                                redirectValid,
    output logic [FrontEndPkg::PcWidth-1:0]                     redirectPc
);

    localparam int PcW  = FrontEndPkg::PcWidth;
    localparam int IdxW = FrontEndPkg::LaneIdxWidth(DecodeWidth);

    logic                                       fullQ;
    logic [DecodeWidth-1:0]                     laneValidQ;
    logic [DecodeWidth-1:0][PcW-1:0]            pcQ;
    logic [DecodeWidth-1:0]                     predTakenQ;
    logic [DecodeWidth-1:0][PcW-1:0]            predAddrQ;
    FrontEndPkg::BranchClassT [DecodeWidth-1:0] brClassQ;
    logic [DecodeWidth-1:0]                     isJalQ;
    logic [DecodeWidth-1:0][PcW-1:0]            decodedPcQ;

    logic            scanDone;
    logic            addrCheck;   // Check lane needs a target compare
    logic            mustFlush;   // Check lane flushes regardless of target
    logic            flush;
    logic [IdxW-1:0] checkLane;

    assign upReady  = !fullQ || outReady;
    assign outValid = fullQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fullQ <= 1'b0;
        end else if (upReady) begin
            fullQ <= upValid;
        end
    end

    always_ff @(posedge clk) begin
        if (upValid && upReady) begin
            laneValidQ <= laneValid;
            pcQ        <= pc;
            predTakenQ <= predTaken;
            predAddrQ  <= predAddr;
            brClassQ   <= brClass;
            isJalQ     <= isJal;
            decodedPcQ <= decodedPc;
        end
    end

    // Scan oldest first and stop at the first lane that settles the group
    always_comb begin
        scanDone  = 1'b0;
        addrCheck = 1'b0;
        mustFlush = 1'b0;
        checkLane = '0;
        for (int i = 0; i < DecodeWidth; i++) begin
            if (!scanDone) begin
                if (!laneValidQ[i]) begin
                    scanDone = 1'b1;
                end else if (brClassQ[i] != FrontEndPkg::ClsPcRelative && predTakenQ[i]) begin
                    checkLane = IdxW'(i);  // Taken prediction on a non-branch
                    mustFlush = 1'b1;
                    scanDone  = 1'b1;
                end else if (brClassQ[i] == FrontEndPkg::ClsPcRelative &&
                             (isJalQ[i] || predTakenQ[i])) begin
                    checkLane = IdxW'(i);
                    addrCheck = 1'b1;
                    scanDone  = 1'b1;
                end else if (brClassQ[i] == FrontEndPkg::ClsIndirect) begin
                    checkLane = IdxW'(i);  // Left for the execute stage
                    scanDone  = 1'b1;
                end else if (brClassQ[i] == FrontEndPkg::ClsSerialized) begin
                    checkLane = IdxW'(i);
                    mustFlush = 1'b1;
                    scanDone  = 1'b1;
                end
            end
        end
    end

    assign flush = mustFlush ||
                   (addrCheck && predAddrQ[checkLane] != decodedPcQ[checkLane]);

    always_comb begin
        for (int i = 0; i < DecodeWidth; i++) begin
            laneFlushed[i]     = flush && (i > checkLane);
            flushTriggering[i] = flush && (i == checkLane);
            laneValidOut[i]    = laneValidQ[i] && !laneFlushed[i];
            // Corrected prediction for the lane that redirects
            predTakenOut[i]    = flushTriggering[i] ? 1'b1 : predTakenQ[i];
            predAddrOut[i]     = flushTriggering[i] ? decodedPcQ[i] : predAddrQ[i];
        end
    end

    assign redirectValid = fullQ && flush;
    assign redirectPc    = decodedPcQ[checkLane];

    assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $onehot0(flushTriggering));

    assert property (@(posedge clk) disable iff (!arstN)
        redirectValid |-> outValid);

    // Stage one gives sequential targets to lanes without a displacement
    for (genvar g = 0; g < DecodeWidth; g++) begin : gSeqTarget
        assert property (@(posedge clk) disable iff (!arstN)
            outValid && laneValidQ[g] && brClassQ[g] != FrontEndPkg::ClsPcRelative
            |-> decodedPcQ[g] == pcQ[g] + PcW'(RiscvIsaPkg::InsnBytes));
    end

endmodule

/* hdl/DecodeFrontEnd.sv */
// ================================================
// Decode front end
// Predecoder followed by the branch resolver
// ================================================
`timescale 1ns/1ps

module DecodeFrontEnd #(
    parameter int DecodeWidth = FrontEndPkg::DefaultDecodeWidth
) (
    input  logic                                                clk,
    input  logic                                                arstN,
    input  logic                                                inValid,
    output logic                                                inReady,
    input  logic [DecodeWidth-1:0]                              laneValidIn,
    input  logic [DecodeWidth-1:0][31:0]                        insn,
    input  logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    pc,
    input  logic [DecodeWidth-1:0]                              predTakenIn,
    input  logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    predAddrIn,
    output logic                                                outValid,
    input  logic                                                outReady,
    output logic [DecodeWidth-1:0]                              laneValidOut,
    output logic [DecodeWidth-1:0]                              laneFlushed,
    output logic [DecodeWidth-1:0]                              flushTriggering,
    output logic [DecodeWidth-1:0]                              predTakenOut,
    output logic [DecodeWidth-1:0][FrontEndPkg::PcWidth-1:0]    predAddrOut,
    output logic                                                redirectValid,
    output logic [FrontEndPkg::PcWidth-1:0]                     redirectPc
);

    localparam int PcW = FrontEndPkg::PcWidth;

    // Stage one to stage two
    logic                                       midValid;
    logic                                       midReady;
    logic [DecodeWidth-1:0]                     midLaneValid;
    logic [DecodeWidth-1:0][PcW-1:0]            midPc;
    logic [DecodeWidth-1:0]                     midPredTaken;
    logic [DecodeWidth-1:0][PcW-1:0]            midPredAddr;
    FrontEndPkg::BranchClassT [DecodeWidth-1:0] midBrClass;
    logic [DecodeWidth-1:0]                     midIsJal;
    logic [DecodeWidth-1:0][PcW-1:0]            midDecodedPc;

    BranchPredecoder #(.DecodeWidth(DecodeWidth)) stage0 (
        .clk(clk), .arstN(arstN),
        .inValid(inValid), .inReady(inReady),
        .laneValidIn(laneValidIn), .insn(insn), .pc(pc),
        .predTakenIn(predTakenIn), .predAddrIn(predAddrIn),
        .downValid(midValid), .downReady(midReady),
        .laneValid(midLaneValid), .pcOut(midPc),
        .predTaken(midPredTaken), .predAddr(midPredAddr),
        .brClass(midBrClass), .isJal(midIsJal), .decodedPc(midDecodedPc)
    );

    DecodedBranchResolver #(.DecodeWidth(DecodeWidth)) stage1 (
        .clk(clk), .arstN(arstN),
        .upValid(midValid), .upReady(midReady),
        .laneValid(midLaneValid), .pc(midPc),
        .predTaken(midPredTaken), .predAddr(midPredAddr),
        .brClass(midBrClass), .isJal(midIsJal), .decodedPc(midDecodedPc),
        .outValid(outValid), .outReady(outReady),
        .laneValidOut(laneValidOut), .laneFlushed(laneFlushed),
        .flushTriggering(flushTriggering),
        .predTakenOut(predTakenOut), .predAddrOut(predAddrOut),
        .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

endmodule

/* verification/ClockGen.sv */
// ==============================================
// Testbench clock and reset
// Free running clock, active low reset held for
// a fixed number of cycles
// ==============================================
`timescale 1ns/1ps

module ClockGen #(
    parameter int PeriodNs    = 20,
    parameter int ResetCycles = 8
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;  // Released away from the active edge
    end

endmodule

/* verification/DecodeFrontEndTb.sv */
// ==================================================
// Testbench for the decode front end
// Directed groups and a back-pressure stream checked
// against a lane scan reference model
// ==================================================
`timescale 1ns/1ps

module DecodeFrontEndTb;

    localparam int          Lanes     = 4;
    localparam logic [31:0] AddiWord  = 32'h00100093;
    localparam logic [31:0] JalrWord  = 32'h000080e7;
    localparam logic [31:0] FenceWord = 32'h0ff0000f;
    localparam logic [31:0] EcallWord = 32'h00000073;

    logic                   clk, arstN, inValid, inReady, outValid, outReady, redirectValid;
    logic [Lanes-1:0]       laneValidIn, predTakenIn, laneValidOut, laneFlushed;
    logic [Lanes-1:0]       flushTriggering, predTakenOut;
    logic [Lanes-1:0][31:0] insn, pc, predAddrIn, predAddrOut;
    logic [31:0]            redirectPc;

    // Group being built, and expected output bundles in send order
    logic [Lanes-1:0]       gValid, gTaken;
    logic [Lanes-1:0][31:0] gInsn, gPc, gAddr;
    logic [176:0]           expQ[$];
    logic [31:0]            lcgState = 32'hf81d39b7;

    ClockGen #(.PeriodNs(20), .ResetCycles(8)) clkGen0 (.clk(clk), .arstN(arstN));

    DecodeFrontEnd #(.DecodeWidth(Lanes)) dut0 (
        .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady),
        .laneValidIn(laneValidIn), .insn(insn), .pc(pc),
        .predTakenIn(predTakenIn), .predAddrIn(predAddrIn),
        .outValid(outValid), .outReady(outReady),
        .laneValidOut(laneValidOut), .laneFlushed(laneFlushed),
        .flushTriggering(flushTriggering), .predTakenOut(predTakenOut),
        .predAddrOut(predAddrOut), .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] encBranch(logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'd0, off[4:1], off[11], 7'h63};  // beq x1, x2
    endfunction

    function automatic logic [31:0] encJal(logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'h6f};
    endfunction

    // Decoded next address straight from the instruction bits
    function automatic logic [31:0] wordTarget(logic [31:0] w, logic [31:0] p);
        case (w[6:0])
            7'h63:   return p + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            7'h6f:   return p + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return p + 32'd4;
        endcase
    endfunction

    function automatic logic [176:0] modelGroup();
        logic [Lanes-1:0]       valid, flushed, trig, taken;
        logic [Lanes-1:0][31:0] addr;
        logic [6:0]             op;
        logic                   rel, done, flush;
        int                     chk;
        valid   = gValid;
        taken   = gTaken;
        addr    = gAddr;
        flushed = '0;
        trig    = '0;
        done    = 1'b0;
        flush   = 1'b0;
        chk     = 0;
        for (int i = 0; i < Lanes; i++) begin
            op  = gInsn[i][6:0];
            rel = (op == 7'h63) || (op == 7'h6f);
            if (!done && gValid[i]) begin
                chk  = i;
                done = 1'b1;
                if (!rel && gTaken[i]) flush = 1'b1;
                else if (rel && (op == 7'h6f || gTaken[i]))
                    flush = gAddr[i] != wordTarget(gInsn[i], gPc[i]);
                else if (op == 7'h0f || op == 7'h73) flush = 1'b1;  // FENCE, SYSTEM
                else if (op != 7'h67) done = 1'b0;  // Plain lane so the scan goes on
            end else begin
                done = 1'b1;  // Scan ends at the first invalid lane
            end
        end
        if (flush) begin
            trig[chk]  = 1'b1;
            taken[chk] = 1'b1;
            addr[chk]  = wordTarget(gInsn[chk], gPc[chk]);
            for (int i = chk + 1; i < Lanes; i++) begin
                flushed[i] = 1'b1;
                valid[i]   = 1'b0;
            end
        end
        return {valid, flushed, trig, taken, addr, flush, addr[chk]};
    endfunction

    function automatic logic [176:0] outputBundle();
        return {laneValidOut, laneFlushed, flushTriggering, predTakenOut, predAddrOut,
                redirectValid, redirectPc};
    endfunction

    task automatic abortRun(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(string name, logic [127:0] expected, logic [127:0] actual);
        if (expected !== actual) begin
            abortRun($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    task automatic checkOutputs(string name, logic [176:0] e);
        check({name, " laneValidOut"}, e[176:173], laneValidOut);
        check({name, " laneFlushed"}, e[172:169], laneFlushed);
        check({name, " flushTriggering"}, e[168:165], flushTriggering);
        check({name, " predTakenOut"}, e[164:161], predTakenOut);
        check({name, " predAddrOut"}, e[160:33], predAddrOut);
        check({name, " redirectValid"}, e[32], redirectValid);
        if (e[32]) check({name, " redirectPc"}, e[31:0], redirectPc);
    endtask

    task automatic driveGroup();
        laneValidIn = gValid;
        insn        = gInsn;
        pc          = gPc;
        predTakenIn = gTaken;
        predAddrIn  = gAddr;
        inValid     = 1'b1;
        expQ.push_back(modelGroup());
    endtask

    task automatic clearGroup(logic [31:0] base);
        for (int i = 0; i < Lanes; i++) begin
            gValid[i] = 1'b1;
            gPc[i]    = base + 32'(4 * i);
            gInsn[i]  = AddiWord;
            gTaken[i] = 1'b0;
            gAddr[i]  = gPc[i] + 32'd4;
        end
    endtask

    task automatic randomGroup();
        logic [31:0] r;
        int          n;
        clearGroup(nextRand() & 32'hffff_fffc);
        n = 1 + int'(nextRand() % 4);  // Valid lanes stay contiguous from lane 0
        for (int i = 0; i < Lanes; i++) begin
            r = nextRand();
            gValid[i] = i < n;
            case (r % 6)
                0:       gInsn[i] = encBranch({r[20:9], 1'b0});
                1:       gInsn[i] = encJal({r[28:9], 1'b0});
                2:       gInsn[i] = JalrWord;
                3:       gInsn[i] = FenceWord;
                4:       gInsn[i] = EcallWord;
                default: gInsn[i] = AddiWord;
            endcase
            gTaken[i] = r[29];
            gAddr[i]  = r[30] ? wordTarget(gInsn[i], gPc[i]) : gPc[i] + {r[31:24], 2'b00};
        end
    endtask

    // One group through an idle pipeline with outReady high
    task automatic runSingle(string name);
        int lat;
        @(negedge clk);
        driveGroup();
        #1;
        check({name, " inReady"}, 1, inReady);
        @(negedge clk);
        inValid = 1'b0;
        lat     = 1;
        #1;
        while (!outValid) begin
            if (lat > 8) abortRun({name, ": no output group before the timeout"});
            @(negedge clk);
            lat++;
            #1;
        end
        check({name, " latency"}, 2, lat);
        checkOutputs(name, expQ.pop_front());
    endtask

    task automatic sendCorrectPrediction();
        logic [31:0] r;
        clearGroup(nextRand() & 32'hffff_fffc);
        r = nextRand();
        gInsn[2]  = encBranch({r[12:1], 1'b0});
        gTaken[2] = 1'b1;
        gAddr[2]  = gPc[2] + {{19{r[12]}}, r[12:1], 1'b0};
        runSingle("correct prediction");
    endtask

    task automatic sweepTargetMismatch();
        logic [31:0] r;
        for (int lane = 0; lane < Lanes; lane++) begin
            clearGroup(nextRand() & 32'hffff_fffc);
            r = nextRand();
            if (lane % 2 == 0) begin
                gInsn[lane] = encJal({r[20:1], 1'b0});
            end else begin
                gInsn[lane]  = encBranch({r[12:1], 1'b0});
                gTaken[lane] = 1'b1;
            end
            gAddr[lane] = wordTarget(gInsn[lane], gPc[lane]) ^ 32'h10;  // Wrong target
            runSingle($sformatf("target mismatch lane %0d", lane));
        end
    endtask

    task automatic flushOnFalseTaken();
        clearGroup(32'h0000_2000);
        gTaken[1] = 1'b1;  // ALU op predicted taken
        gInsn[3]  = FenceWord;
        runSingle("false taken alu");
        clearGroup(32'h0000_3000);
        gInsn[0]  = FenceWord;
        gInsn[2]  = EcallWord;
        gTaken[2] = 1'b1;
        runSingle("serialized fence");
    endtask

    task automatic skipIndirectAndInvalid();
        clearGroup(32'h0000_4000);
        gInsn[0]  = JalrWord;
        gInsn[1]  = encBranch(13'h0020);
        gTaken[1] = 1'b1;
        gAddr[1]  = 32'h0;
        runSingle("jalr ahead of branch");
        clearGroup(32'h0000_5000);
        gValid    = 4'b0011;
        gInsn[2]  = encBranch(13'h1ff0);
        gTaken[2] = 1'b1;
        gAddr[2]  = 32'h0;
        runSingle("branch after invalid lane");
    endtask

    task automatic streamGroups(int count);
        logic [176:0] held;
        bit           holding = 1'b0;
        bit           fired = 1'b0;
        int           sent = 0;
        int           got = 0;
        int           stall = 0;
        while (got < count) begin
            @(negedge clk);
            if (fired) inValid = 1'b0;
            if (!inValid && sent < count) begin
                randomGroup();
                driveGroup();
                sent++;
            end
            outReady = nextRand() >= 32'h8000_0000;
            #1;
            fired = inValid && inReady;
            if (holding) begin
                check("back-pressure hold outValid", 1, outValid);
                checkOutputs("back-pressure hold", held);
            end
            holding = outValid && !outReady;
            held    = outputBundle();
            if (outValid && outReady) begin
                if (expQ.size() == 0) abortRun("back-pressure: DUT presented an unsent group");
                checkOutputs($sformatf("back-pressure group %0d", got), expQ.pop_front());
                got++;
                stall = 0;
            end else begin
                stall++;
                if (stall > 50) abortRun("back-pressure: no group delivered before the timeout");
            end
        end
        outReady = 1'b1;
    endtask

    initial begin
        int t;
        t           = 0;
        inValid     = 1'b0;
        outReady    = 1'b1;
        laneValidIn = '0;
        insn        = '0;
        pc          = '0;
        predTakenIn = '0;
        predAddrIn  = '0;
        while (arstN !== 1'b1) begin
            @(negedge clk);
            t++;
            if (t > 20) abortRun("reset was never released");
        end
        #1;
        check("reset inReady", 1, inReady);
        check("reset outValid", 0, outValid);
        check("reset redirectValid", 0, redirectValid);
        sendCorrectPrediction();
        sweepTargetMismatch();
        flushOnFalseTaken();
        skipIndirectAndInvalid();
        streamGroups(20);
        if (expQ.size() != 0) begin
            abortRun("groups were sent but never came out");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* DecodeFrontEnd.f */
hdl/RiscvIsaPkg.sv
hdl/FrontEndPkg.sv
hdl/BranchPredecoder.sv
hdl/DecodedBranchResolver.sv
hdl/DecodeFrontEnd.sv
verification/ClockGen.sv
verification/DecodeFrontEndTb.sv

/* Bender.yml */
package:
  name: decode_front_end

sources:
  - files:
      - hdl/RiscvIsaPkg.sv
      - hdl/FrontEndPkg.sv
      - hdl/BranchPredecoder.sv
      - hdl/DecodedBranchResolver.sv
      - hdl/DecodeFrontEnd.sv
  - target: test
    files:
      - verification/ClockGen.sv
      - verification/DecodeFrontEndTb.sv
